// ==== source/mcalu16_pkg.sv ====
package mcalu16_pkg;

	// ==================================================
	// Value and tag types
	// ==================================================

	// One 16-bit word, read as an IEEE half or as a two's-complement integer
	// Bit 15 is the sign, bits 14:10 the biased exponent, bits 9:0 the fraction
	typedef logic [15:0] half_value_t;

	// Thread tag that rides along with every operation
	typedef logic [3:0] tid_t;

	// ==================================================
	// Operation codes
	// ==================================================

	// Plain operation code in place of a full instruction word
	// The two codes past OP_FTRUNC are unused and give a zero result
	typedef enum logic [2:0] {
		OP_NOP    = 3'd0,
		OP_MUL    = 3'd1,
		OP_MULI   = 3'd2,
		OP_I2F    = 3'd3,
		OP_F2I    = 3'd4,
		OP_FTRUNC = 3'd5
	} op_e;

	// ==================================================
	// Timing and format constants
	// ==================================================

	// Cycles from the issue edge to the done cycle
	localparam int unsigned LATENCY = 8;

	// Register stages inside the converters and the multiplier
	localparam int unsigned UNIT_STAGES = 1;

	// Remaining depth carried by the delay lines after the result select
	localparam int unsigned TAIL_STAGES = LATENCY - UNIT_STAGES;

	// Half-precision exponent bias
	localparam int unsigned HALF_BIAS = 15;

	// Half-precision fraction width, without the hidden one
	localparam int unsigned HALF_FRAC_W = 10;

endpackage

// ==== source/delay_line.sv ====
module delay_line #(
	parameter type T = logic,
	parameter int unsigned DEPTH = 1
) (
	input  logic clk_i,
	input  logic arst_n_i,
	input  T     d_i,
	output T     q_o
);

	// One register per stage of delay
	T stage_q [DEPTH];

	// Every word moves one stage per clock, so the output is d_i from DEPTH edges ago
	// The reset clears every stage, which keeps a valid bit payload low until
	// real issues have travelled through
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// Last stage drives the output
	assign q_o = stage_q[DEPTH-1];

endmodule

// ==== source/i2f16.sv ====
module i2f16 (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  mcalu16_pkg::half_value_t a_i,
	output mcalu16_pkg::half_value_t o_o
);

	logic                                sign;
	logic [15:0]                         mag;
	logic [3:0]                          lead;
	logic [15:0]                         norm;
	logic [mcalu16_pkg::HALF_FRAC_W-1:0] frac;
	logic                                guard;
	logic                                sticky;
	logic                                round_up;
	logic [4:0]                          exp_raw;
	logic [14:0]                         rounded;
	mcalu16_pkg::half_value_t            result;

	// Magnitude of the signed input
	// For -32768 the negation wraps to 0x8000, which read unsigned is the right magnitude
	assign sign = a_i[15];
	assign mag  = sign ? (~a_i + 16'd1) : a_i;

	// Leading one search
	// The highest set bit wins because later loop passes overwrite earlier ones
	always_comb begin
		lead = '0;
		for (int i = 0; i < 16; i++) begin
			if (mag[i]) begin
				lead = 4'(i);
			end
		end
	end

	// Shift the leading one up to bit 15, so bit 15 is the hidden one
	assign norm = mag << (4'd15 - lead);

	// ==================================================
	// Round to nearest, ties to even
	// ==================================================

	// The ten bits below the hidden one form the fraction
	assign frac = norm[14 -: mcalu16_pkg::HALF_FRAC_W];

	// Guard is the first dropped bit and sticky ORs all the rest
	assign guard  = norm[14 - mcalu16_pkg::HALF_FRAC_W];
	assign sticky = |norm[13 - mcalu16_pkg::HALF_FRAC_W:0];

	// On an exact tie the fraction LSB decides, which lands on the even neighbour
	assign round_up = guard & (sticky | frac[0]);

	// Exponent is the bias plus the position of the leading one
	assign exp_raw = 5'(mcalu16_pkg::HALF_BIAS) + {1'b0, lead};

	// Adding across exponent and fraction lets a fraction carry bump the exponent
	// 32767 rounds up this way to 0x7800
	assign rounded = {exp_raw, frac} + 15'(round_up);

	// Zero has no leading one and maps to positive zero
	assign result = (mag == '0) ? '0 : {sign, rounded};

	// Output register, the unit's single stage
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			o_o <= '0;
		end else begin
			o_o <= result;
		end
	end

endmodule

// ==== source/f2i16.sv ====
module f2i16 (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  mcalu16_pkg::half_value_t a_i,
	output mcalu16_pkg::half_value_t o_o
);

	logic                                sign;
	logic [4:0]                          exp_b;
	logic [mcalu16_pkg::HALF_FRAC_W-1:0] frac;
	logic [3:0]                          shamt;
	logic [25:0]                         wide;
	logic [15:0]                         mag;
	mcalu16_pkg::half_value_t            result;

	// Field split of the half
	assign sign  = a_i[15];
	assign exp_b = a_i[14:10];
	assign frac  = a_i[mcalu16_pkg::HALF_FRAC_W-1:0];

	// Unbiased exponent
	// It only matters in the in-range case, where it lies between 0 and 14
	assign shamt = 4'(exp_b - 5'(mcalu16_pkg::HALF_BIAS));

	// Hidden-one significand scaled by 2^e, then the fraction bits dropped
	// Dropping them is what truncates toward zero on the magnitude
	assign wide = 26'({1'b1, frac}) << shamt;
	assign mag  = 16'(wide >> mcalu16_pkg::HALF_FRAC_W);

	always_comb begin
		if (exp_b == 5'h1f && frac != '0) begin
			// NaN has no integer value
			result = '0;
		end else if (exp_b < 5'(mcalu16_pkg::HALF_BIAS)) begin
			// Magnitude below one truncates to zero
			result = '0;
		end else if (exp_b >= 5'(mcalu16_pkg::HALF_BIAS + 15)) begin
			// 2^15 and above, infinity included, clamp to the integer range
			result = sign ? 16'h8000 : 16'h7fff;
		end else begin
			// Two's-complement negate for a negative sign
			result = sign ? (~mag + 16'd1) : mag;
		end
	end

	// Output register, the unit's single stage
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			o_o <= '0;
		end else begin
			o_o <= result;
		end
	end

endmodule

// ==== source/fp_trunc16.sv ====
module fp_trunc16 (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  mcalu16_pkg::half_value_t a_i,
	output mcalu16_pkg::half_value_t o_o
);

	logic [4:0]                          exp_b;
	logic [3:0]                          drop;
	logic [mcalu16_pkg::HALF_FRAC_W-1:0] keep_mask;
	mcalu16_pkg::half_value_t            result;

	assign exp_b = a_i[14:10];

	// Number of fraction bits that sit below the binary point
	// With exponent e it is 10 - e, between 1 and 10 in the range that uses it
	assign drop = 4'(5'(mcalu16_pkg::HALF_BIAS + mcalu16_pkg::HALF_FRAC_W) - exp_b);

	// Mask keeps only the fraction bits at or above the binary point
	assign keep_mask = {mcalu16_pkg::HALF_FRAC_W{1'b1}} << drop;

	always_comb begin
		if (exp_b < 5'(mcalu16_pkg::HALF_BIAS)) begin
			// Below one the result is a signed zero
			result = {a_i[15], 15'b0};
		end else if (exp_b >= 5'(mcalu16_pkg::HALF_BIAS + mcalu16_pkg::HALF_FRAC_W)) begin
			// Already integral, and infinity or NaN pass through as they are
			result = a_i;
		end else begin
			result = {a_i[15:10], a_i[mcalu16_pkg::HALF_FRAC_W-1:0] & keep_mask};
		end
	end

	// Output register, the unit's single stage
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			o_o <= '0;
		end else begin
			o_o <= result;
		end
	end

endmodule

// ==== source/mcalu16.sv ====
module mcalu16 (
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     valid_i,
	input  mcalu16_pkg::op_e         op_i,
	input  mcalu16_pkg::half_value_t a_i,
	input  mcalu16_pkg::half_value_t b_i,
	input  mcalu16_pkg::half_value_t imm_i,
	input  mcalu16_pkg::tid_t        tid_i,
	output mcalu16_pkg::half_value_t o_o,
	output logic                     done_o,
	output mcalu16_pkg::tid_t        tid_o
);

	// Converter outputs, already one stage late
	mcalu16_pkg::half_value_t i2f_q;
	mcalu16_pkg::half_value_t f2i_q;
	mcalu16_pkg::half_value_t ftrunc_q;

	// Multiplier path
	mcalu16_pkg::half_value_t mul_operand;
	mcalu16_pkg::half_value_t mul_d;
	mcalu16_pkg::half_value_t mul_q;

	// Control that travels with the unit stage
	mcalu16_pkg::op_e  op_q;
	mcalu16_pkg::tid_t tid_q;
	logic              valid_q;

	// Selected result at the end of the unit stage
	mcalu16_pkg::half_value_t result;

	// ==================================================
	// Unit stage
	// ==================================================

	// All three converters see A every cycle
	// Only the one picked by the registered op code reaches the output
	i2f16 i_i2f16 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.a_i      (a_i),
		.o_o      (i2f_q)
	);

	f2i16 i_f2i16 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.a_i      (a_i),
		.o_o      (f2i_q)
	);

	fp_trunc16 i_fp_trunc16 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.a_i      (a_i),
		.o_o      (ftrunc_q)
	);

	// MULI takes the immediate as second operand, every other code takes B
	assign mul_operand = (op_i == mcalu16_pkg::OP_MULI) ? imm_i : b_i;

	// Unsigned product sized to 16 bits, so only the low half of A times B is kept
	assign mul_d = mcalu16_pkg::half_value_t'(a_i * mul_operand);

	// Product, op code, tag and valid are captured on the same edge as the converters
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mul_q   <= '0;
			op_q    <= mcalu16_pkg::OP_NOP;
			tid_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			mul_q   <= mul_d;
			op_q    <= op_i;
			tid_q   <= tid_i;
			valid_q <= valid_i;
		end
	end

	// ==================================================
	// Result select
	// ==================================================

	// Steered by op_q, which belongs to the same issue as the unit outputs
	always_comb begin
		case (op_q)
			mcalu16_pkg::OP_MUL,
			mcalu16_pkg::OP_MULI:   result = mul_q;
			mcalu16_pkg::OP_I2F:    result = i2f_q;
			mcalu16_pkg::OP_F2I:    result = f2i_q;
			mcalu16_pkg::OP_FTRUNC: result = ftrunc_q;
			// OP_NOP and the two spare codes
			default:                result = '0;
		endcase
	end

	// ==================================================
	// Tail delay to the full latency
	// ==================================================

	// Result, tag and valid stay aligned by going through equal depths
	delay_line #(
		.T     (mcalu16_pkg::half_value_t),
		.DEPTH (mcalu16_pkg::TAIL_STAGES)
	) i_result_dly (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.d_i      (result),
		.q_o      (o_o)
	);

	delay_line #(
		.T     (mcalu16_pkg::tid_t),
		.DEPTH (mcalu16_pkg::TAIL_STAGES)
	) i_tid_dly (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.d_i      (tid_q),
		.q_o      (tid_o)
	);

	// The delayed valid bit is the done pulse
	delay_line #(
		.T     (logic),
		.DEPTH (mcalu16_pkg::TAIL_STAGES)
	) i_valid_dly (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.d_i      (valid_q),
		.q_o      (done_o)
	);

endmodule

// ==== verification/mcalu16_asserts.sv ====
module mcalu16_asserts (
	input logic              clk_i,
	input logic              arst_n_i,
	input logic              valid_i,
	input logic              done_i,
	input mcalu16_pkg::tid_t tid_i,
	input mcalu16_pkg::tid_t tid_out_i
);

	// ==================================================
	// Done and tag timing
	// ==================================================

	// The cleared pipeline keeps done low for the whole reset
	a_done_low_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !done_i)
		else $error("done_o was high during reset");

	// Every issue edge shows up as a done cycle LATENCY edges later, and nothing else does
	a_done_follows_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		done_i == $past(valid_i, mcalu16_pkg::LATENCY))
		else $error("done_o does not match valid_i from LATENCY cycles earlier");

	// The tag leaves with its own result
	a_tag_follows_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		done_i |-> tid_out_i == $past(tid_i, mcalu16_pkg::LATENCY))
		else $error("tid_o does not match the tag issued LATENCY cycles earlier");

endmodule

bind mcalu16 mcalu16_asserts i_mcalu16_asserts (
	.clk_i     (clk_i),
	.arst_n_i  (arst_n_i),
	.valid_i   (valid_i),
	.done_i    (done_o),
	.tid_i     (tid_i),
	.tid_out_i (tid_o)
);

// ==== verification/tb_mcalu16.sv ====
module tb_mcalu16;

	// Generous ceiling over the roughly one hundred cycles the tests use
	localparam int unsigned MAX_CYCLES = 2000;

	logic                     clk_i;
	logic                     arst_n_i;
	logic                     valid_i;
	mcalu16_pkg::op_e         op_i;
	mcalu16_pkg::half_value_t a_i;
	mcalu16_pkg::half_value_t b_i;
	mcalu16_pkg::half_value_t imm_i;
	mcalu16_pkg::tid_t        tid_i;
	mcalu16_pkg::half_value_t o_o;
	logic                     done_o;
	mcalu16_pkg::tid_t        tid_o;

	int          seed = 79110;
	int unsigned cycle_count = 0;

	// Expected responses in issue order, with the cycle in which valid_i was high
	mcalu16_pkg::half_value_t exp_result_q [$];
	mcalu16_pkg::tid_t        exp_tid_q [$];
	int unsigned              issue_cycle_q [$];

	// ==================================================
	// Reference tables for the converters
	// ==================================================

	// 0, 1, -1, 2049 (tie to even, down), 2051 (tie to even, up), 32767, -32768
	mcalu16_pkg::half_value_t i2f_in [7] = '{16'h0000, 16'h0001, 16'hffff, 16'd2049,
		16'd2051, 16'h7fff, 16'h8000};
	mcalu16_pkg::half_value_t i2f_out [7] = '{16'h0000, 16'h3c00, 16'hbc00, 16'h6800,
		16'h6802, 16'h7800, 16'hf800};

	// 1.5, -1.5, 0.5, 32768, minus infinity, NaN
	mcalu16_pkg::half_value_t f2i_in [6] = '{16'h3e00, 16'hbe00, 16'h3800, 16'h7800,
		16'hfc00, 16'h7e00};
	mcalu16_pkg::half_value_t f2i_out [6] = '{16'h0001, 16'hffff, 16'h0000, 16'h7fff,
		16'h8000, 16'h0000};

	// 2.5, -2.5, -0.5, 4100 and infinity
	mcalu16_pkg::half_value_t ftrunc_in [5] = '{16'h4100, 16'hc100, 16'hb800, 16'h6c01,
		16'h7c00};
	mcalu16_pkg::half_value_t ftrunc_out [5] = '{16'h4000, 16'hc000, 16'h8000, 16'h6c01,
		16'h7c00};

	mcalu16 i_mcalu16 (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.valid_i  (valid_i),
		.op_i     (op_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.imm_i    (imm_i),
		.tid_i    (tid_i),
		.o_o      (o_o),
		.done_o   (done_o),
		.tid_o    (tid_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_half(input mcalu16_pkg::half_value_t expected,
		input mcalu16_pkg::half_value_t actual, input string what);
		if (actual !== expected) begin
			fail_run($sformatf("Error at time %0t: %s expected 0x%h, got 0x%h",
				$time, what, expected, actual));
		end
	endtask

	task automatic check_tid(input mcalu16_pkg::tid_t expected,
		input mcalu16_pkg::tid_t actual, input string what);
		if (actual !== expected) begin
			fail_run($sformatf("Error at time %0t: %s expected %0d, got %0d",
				$time, what, expected, actual));
		end
	endtask

	// Low half of the full 32-bit unsigned product
	function automatic mcalu16_pkg::half_value_t low_product(input mcalu16_pkg::half_value_t x,
		input mcalu16_pkg::half_value_t y);
		logic [31:0] full;
		full = {16'b0, x} * {16'b0, y};
		return full[15:0];
	endfunction

	// Cycle counter that also ends a hung run
	always @(posedge clk_i) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > MAX_CYCLES) begin
			fail_run($sformatf("Timeout: the run went past %0d cycles", MAX_CYCLES));
		end
	end

	// ==================================================
	// Response monitor, sampling in the middle of the cycle
	// ==================================================

	always @(negedge clk_i) begin
		if (!arst_n_i) begin
			if (done_o !== 1'b0) begin
				fail_run("done_o was not low while reset was asserted");
			end
		end else if (done_o === 1'b1) begin
			if (exp_result_q.size() == 0) begin
				fail_run("done_o pulsed while no operation was in flight");
			end else if (cycle_count - issue_cycle_q[0] != mcalu16_pkg::LATENCY) begin
				fail_run($sformatf("done_o came %0d cycles after issue instead of %0d",
					cycle_count - issue_cycle_q[0], mcalu16_pkg::LATENCY));
			end else begin
				check_half(exp_result_q.pop_front(), o_o, "result");
				check_tid(exp_tid_q.pop_front(), tid_o, "tag");
				void'(issue_cycle_q.pop_front());
			end
		end else if (done_o !== 1'b0) begin
			fail_run("done_o was unknown after reset");
		end
	end

	// Holds one operation on the inputs across one rising edge
	// Called 1 time unit after an edge, and returns 1 time unit after the next one
	task automatic issue(input mcalu16_pkg::op_e op, input mcalu16_pkg::half_value_t a,
		input mcalu16_pkg::half_value_t b, input mcalu16_pkg::half_value_t imm,
		input mcalu16_pkg::tid_t tid, input mcalu16_pkg::half_value_t expected);
		valid_i = 1'b1;
		op_i    = op;
		a_i     = a;
		b_i     = b;
		imm_i   = imm;
		tid_i   = tid;
		exp_result_q.push_back(expected);
		exp_tid_q.push_back(tid);
		issue_cycle_q.push_back(cycle_count);
		@(posedge clk_i);
		#1;
		valid_i = 1'b0;
	endtask

	task automatic wait_all_done();
		while (exp_result_q.size() != 0) begin
			@(negedge clk_i);
		end
		@(posedge clk_i);
		#1;
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_mul();
		mcalu16_pkg::half_value_t a;
		mcalu16_pkg::half_value_t b;
		mcalu16_pkg::half_value_t imm;
		for (int i = 0; i < 4; i++) begin
			a   = 16'($random(seed));
			b   = 16'($random(seed));
			imm = 16'($random(seed));
			// B and the immediate must differ so that a wrong operand select is caught
			if (imm == b) begin
				imm = ~b;
			end
			issue(mcalu16_pkg::OP_MUL, a, b, imm, 4'(i), low_product(a, b));
			issue(mcalu16_pkg::OP_MULI, a, b, imm, 4'(i + 4), low_product(a, imm));
		end
		wait_all_done();
	endtask

	task automatic test_i2f();
		for (int k = 0; k < 7; k++) begin
			issue(mcalu16_pkg::OP_I2F, i2f_in[k], 16'($random(seed)), 16'($random(seed)),
				4'(k), i2f_out[k]);
		end
		wait_all_done();
	endtask

	task automatic test_f2i();
		for (int k = 0; k < 6; k++) begin
			issue(mcalu16_pkg::OP_F2I, f2i_in[k], 16'($random(seed)), 16'($random(seed)),
				4'(k), f2i_out[k]);
		end
		wait_all_done();
	endtask

	task automatic test_ftrunc();
		for (int k = 0; k < 5; k++) begin
			issue(mcalu16_pkg::OP_FTRUNC, ftrunc_in[k], 16'($random(seed)),
				16'($random(seed)), 4'(k), ftrunc_out[k]);
		end
		wait_all_done();
	endtask

	// Eight back-to-back issues cycling through all five op codes
	task automatic test_stream();
		mcalu16_pkg::half_value_t a;
		mcalu16_pkg::half_value_t b;
		mcalu16_pkg::half_value_t imm;
		mcalu16_pkg::half_value_t expected;
		mcalu16_pkg::op_e         op;
		int                       k;
		for (int i = 0; i < 8; i++) begin
			a   = 16'($random(seed));
			b   = 16'($random(seed));
			imm = 16'($random(seed));
			case (i % 5)
				0: begin
					op       = mcalu16_pkg::OP_MUL;
					expected = low_product(a, b);
				end
				1: begin
					op       = mcalu16_pkg::OP_MULI;
					expected = low_product(a, imm);
				end
				2: begin
					k        = {$random(seed)} % 7;
					op       = mcalu16_pkg::OP_I2F;
					a        = i2f_in[k];
					expected = i2f_out[k];
				end
				3: begin
					k        = {$random(seed)} % 6;
					op       = mcalu16_pkg::OP_F2I;
					a        = f2i_in[k];
					expected = f2i_out[k];
				end
				default: begin
					k        = {$random(seed)} % 5;
					op       = mcalu16_pkg::OP_FTRUNC;
					a        = ftrunc_in[k];
					expected = ftrunc_out[k];
				end
			endcase
			issue(op, a, b, imm, 4'(i), expected);
		end
		wait_all_done();
	endtask

	// NOP and the two spare codes, all with valid_i high, must give zero
	task automatic test_unused();
		issue(mcalu16_pkg::OP_NOP, 16'h1234, 16'h5678, 16'h9abc, 4'd8, 16'h0000);
		issue(mcalu16_pkg::op_e'(3'd6), 16'h4100, 16'h0003, 16'h0005, 4'd9, 16'h0000);
		issue(mcalu16_pkg::op_e'(3'd7), 16'h7fff, 16'hffff, 16'h0001, 4'd10, 16'h0000);
		wait_all_done();
	endtask

	initial begin
		arst_n_i = 1'b0;
		valid_i  = 1'b0;
		op_i     = mcalu16_pkg::OP_NOP;
		a_i      = '0;
		b_i      = '0;
		imm_i    = '0;
		tid_i    = '0;
		repeat (10) @(posedge clk_i);
		#1;
		arst_n_i = 1'b1;
		test_mul();
		test_i2f();
		test_f2i();
		test_ftrunc();
		test_stream();
		test_unused();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== list.f ====
source/mcalu16_pkg.sv
source/delay_line.sv
source/i2f16.sv
source/f2i16.sv
source/fp_trunc16.sv
source/mcalu16.sv
verification/mcalu16_asserts.sv
verification/tb_mcalu16.sv

// ==== Bender.yml ====
package:
  name: mcalu16

sources:
  - source/mcalu16_pkg.sv
  - source/delay_line.sv
  - source/i2f16.sv
  - source/f2i16.sv
  - source/fp_trunc16.sv
  - source/mcalu16.sv
  - target: test
    files:
      - verification/mcalu16_asserts.sv
      - verification/tb_mcalu16.sv
